/* rtl/periph_config.svh */
// Counts, widths and address map of the peripheral subsystem, included by RTL and testbench
`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// Interrupt sources and targets
`define PERIPH_NUM_SRC 4
`define PERIPH_NUM_TGT 2
`define PERIPH_PRIO_W 3

`define PERIPH_TIMER_CNT 2

// Register bus
`define PERIPH_ADDR_W 16
`define PERIPH_UNMAPPED_DATA 32'hDEAD_BEEF

`endif

/* rtl/bus_pkg.sv */
// Register bus types and address map constants shared by the decoder and register stages
`include "periph_config.svh"

package bus_pkg;

    typedef logic [`PERIPH_ADDR_W-1:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [11:0] offset_t;
    typedef logic [3:0] region_t;

    // Address bits 15:12
    localparam region_t REGION_PLIC = 4'd0;
    localparam region_t REGION_TIMER = 4'd1;

    // PLIC offsets
    localparam offset_t PRIO_BASE = 12'h000;
    localparam offset_t ENABLE_BASE = 12'h100;
    localparam offset_t THRESH_BASE = 12'h200;

    // Timer n at n * stride, then ctrl, count, compare
    localparam offset_t TIMER_STRIDE = 12'h010;

endpackage

/* rtl/irq_pkg.sv */
// Interrupt source, priority and gateway state types shared by the interrupt stages
`include "periph_config.svh"

package irq_pkg;

    // Id 0 means no source
    typedef logic [2:0] src_id_t;
    typedef logic [`PERIPH_PRIO_W-1:0] prio_t;

    // Bit id-1 per source
    typedef logic [`PERIPH_NUM_SRC-1:0] src_vec_t;

    typedef enum logic [1:0] {
        GW_IDLE,
        GW_PENDING,
        GW_ACTIVE
    } gw_state_e;

endpackage

/* rtl/reg_decode.sv */
// Register bus front end, routes each request by region and returns the response a cycle later
`timescale 1ns/1ps
`include "periph_config.svh"

module reg_decode (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic             req_i,
    input  logic             we_i,
    input  bus_pkg::addr_t   addr_i,
    input  bus_pkg::data_t   wdata_i,
    input  bus_pkg::data_t   plic_rdata_i,
    input  bus_pkg::data_t   timer_rdata_i,
    output logic             plic_sel_o,
    output logic             timer_sel_o,
    output logic             we_o,
    output bus_pkg::offset_t offset_o,
    output bus_pkg::data_t   wdata_o,
    output logic             rvalid_o,
    output bus_pkg::data_t   rdata_o,
    output logic             err_o
);

    bus_pkg::region_t region;
    bus_pkg::data_t   rsp_data;
    logic             unmapped;

    assign region = addr_i[15:12];

    // Region selects
    assign plic_sel_o  = req_i && (region == bus_pkg::REGION_PLIC);
    assign timer_sel_o = req_i && (region == bus_pkg::REGION_TIMER);
    assign unmapped    = !(region == bus_pkg::REGION_PLIC || region == bus_pkg::REGION_TIMER);

    assign we_o     = we_i;
    assign offset_o = addr_i[11:0];
    assign wdata_o  = wdata_i;

    always_comb begin
        case (region)
            bus_pkg::REGION_PLIC:  rsp_data = plic_rdata_i;
            bus_pkg::REGION_TIMER: rsp_data = timer_rdata_i;
            default:               rsp_data = `PERIPH_UNMAPPED_DATA;
        endcase
    end

    // --------------------
    // Response, one cycle after the request
    // --------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rvalid_o <= 1'b0;
            err_o    <= 1'b0;
        end else begin
            rvalid_o <= req_i;
            err_o    <= req_i && unmapped;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            rdata_o <= rsp_data;
        end
    end

    // Every request answered on the very next cycle, never otherwise
    assert property (@(posedge clk_i) disable iff (!arst_n_i) rvalid_o == $past(req_i));

endmodule

/* rtl/timer_bank.sv */
// Bank of compare timers, each raising a one-cycle interrupt pulse per match
`timescale 1ns/1ps
`include "periph_config.svh"

module timer_bank (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         sel_i,
    input  logic                         we_i,
    input  bus_pkg::offset_t             offset_i,
    input  bus_pkg::data_t               wdata_i,
    output bus_pkg::data_t               rdata_o,
    output logic [`PERIPH_TIMER_CNT-1:0] irq_o
);

    logic [`PERIPH_TIMER_CNT-1:0] ctrl_q;
    bus_pkg::data_t               count_q [`PERIPH_TIMER_CNT];
    bus_pkg::data_t               cmp_q [`PERIPH_TIMER_CNT];
    bus_pkg::offset_t             base [`PERIPH_TIMER_CNT];

    always_comb begin
        for (int n = 0; n < `PERIPH_TIMER_CNT; n++) begin
            base[n] = bus_pkg::offset_t'(n) * bus_pkg::TIMER_STRIDE;
        end
    end

    // Register read mux
    always_comb begin
        rdata_o = '0;
        for (int n = 0; n < `PERIPH_TIMER_CNT; n++) begin
            if (offset_i == base[n]) begin
                rdata_o = bus_pkg::data_t'(ctrl_q[n]);
            end
            if (offset_i == base[n] + 12'h4) begin
                rdata_o = count_q[n];
            end
            if (offset_i == base[n] + 12'h8) begin
                rdata_o = cmp_q[n];
            end
        end
    end

    // --------------------
    // Counters and register writes
    // --------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_q  <= '0;
            count_q <= '{default: '0};
            cmp_q   <= '{default: '0};
            irq_o   <= '0;
        end else begin
            for (int n = 0; n < `PERIPH_TIMER_CNT; n++) begin
                irq_o[n] <= 1'b0;
                if (ctrl_q[n]) begin
                    if (count_q[n] == cmp_q[n]) begin
                        count_q[n] <= '0;
                        // Compare of 0 would otherwise hold the line high
                        irq_o[n]   <= !irq_o[n];
                    end else begin
                        count_q[n] <= count_q[n] + 32'd1;
                    end
                end
                // Software write wins over the count update
                if (sel_i && we_i) begin
                    if (offset_i == base[n]) begin
                        ctrl_q[n] <= wdata_i[0];
                    end
                    if (offset_i == base[n] + 12'h4) begin
                        count_q[n] <= wdata_i;
                    end
                    if (offset_i == base[n] + 12'h8) begin
                        cmp_q[n] <= wdata_i;
                    end
                end
            end
        end
    end

    // Gateway relies on single pulses per match
    assert property (@(posedge clk_i) disable iff (!arst_n_i) (irq_o & $past(irq_o)) == '0);

endmodule

/* rtl/irq_gateway.sv */
// Interrupt gateway, holds each source pending or in service until software completes it
`timescale 1ns/1ps
`include "periph_config.svh"

module irq_gateway (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  irq_pkg::src_vec_t  src_i,
    input  logic               claim_valid_i,
    input  irq_pkg::src_id_t   claim_id_i,
    input  logic               complete_valid_i,
    input  irq_pkg::src_id_t   complete_id_i,
    output irq_pkg::src_vec_t  pending_o
);

    irq_pkg::gw_state_e state_q [`PERIPH_NUM_SRC];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= '{default: irq_pkg::GW_IDLE};
        end else begin
            for (int s = 0; s < `PERIPH_NUM_SRC; s++) begin
                case (state_q[s])
                    irq_pkg::GW_IDLE: begin
                        if (src_i[s]) begin
                            state_q[s] <= irq_pkg::GW_PENDING;
                        end
                    end
                    irq_pkg::GW_PENDING: begin
                        if (claim_valid_i && claim_id_i == irq_pkg::src_id_t'(s + 1)) begin
                            state_q[s] <= irq_pkg::GW_ACTIVE;
                        end
                    end
                    irq_pkg::GW_ACTIVE: begin
                        // Level still high just re-enters pending afterwards
                        if (complete_valid_i && complete_id_i == irq_pkg::src_id_t'(s + 1)) begin
                            state_q[s] <= irq_pkg::GW_IDLE;
                        end
                    end
                    default: state_q[s] <= irq_pkg::GW_IDLE;
                endcase
            end
        end
    end

    always_comb begin
        for (int s = 0; s < `PERIPH_NUM_SRC; s++) begin
            pending_o[s] = (state_q[s] == irq_pkg::GW_PENDING);
        end
    end

    for (genvar s = 0; s < `PERIPH_NUM_SRC; s++) begin : gen_chk
        assert property (@(posedge clk_i) disable iff (!arst_n_i)
            !(pending_o[s] && state_q[s] == irq_pkg::GW_ACTIVE));
    end

endmodule

/* rtl/irq_arbiter.sv */
// Interrupt arbiter with priority, enable, threshold and claim registers for each target
`timescale 1ns/1ps
`include "periph_config.svh"

module irq_arbiter (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       sel_i,
    input  logic                       we_i,
    input  bus_pkg::offset_t           offset_i,
    input  bus_pkg::data_t             wdata_i,
    input  irq_pkg::src_vec_t          pending_i,
    output bus_pkg::data_t             rdata_o,
    output logic                       claim_valid_o,
    output irq_pkg::src_id_t           claim_id_o,
    output logic                       complete_valid_o,
    output irq_pkg::src_id_t           complete_id_o,
    output logic [`PERIPH_NUM_TGT-1:0] irq_o
);

    irq_pkg::prio_t             prio_q [`PERIPH_NUM_SRC];
    irq_pkg::src_vec_t          enable_q [`PERIPH_NUM_TGT];
    irq_pkg::prio_t             thresh_q [`PERIPH_NUM_TGT];
    irq_pkg::src_id_t           max_id_q [`PERIPH_NUM_TGT];
    irq_pkg::src_id_t           best_id [`PERIPH_NUM_TGT];
    irq_pkg::prio_t             best_prio [`PERIPH_NUM_TGT];
    logic [`PERIPH_NUM_SRC-1:0] prio_hit;
    logic [`PERIPH_NUM_TGT-1:0] en_hit;
    logic [`PERIPH_NUM_TGT-1:0] thr_hit;
    logic [`PERIPH_NUM_TGT-1:0] claim_hit;

    // --------------------
    // Offset decode
    // --------------------
    always_comb begin
        for (int s = 0; s < `PERIPH_NUM_SRC; s++) begin
            prio_hit[s] = offset_i == bus_pkg::PRIO_BASE + bus_pkg::offset_t'(4 * (s + 1));
        end
        for (int t = 0; t < `PERIPH_NUM_TGT; t++) begin
            en_hit[t]    = offset_i == bus_pkg::ENABLE_BASE + bus_pkg::offset_t'(4 * t);
            thr_hit[t]   = offset_i == bus_pkg::THRESH_BASE + bus_pkg::offset_t'(8 * t);
            claim_hit[t] = offset_i == bus_pkg::THRESH_BASE + bus_pkg::offset_t'(8 * t + 4);
        end
    end

    always_comb begin
        rdata_o = '0;
        for (int s = 0; s < `PERIPH_NUM_SRC; s++) begin
            if (prio_hit[s]) begin
                rdata_o = bus_pkg::data_t'(prio_q[s]);
            end
        end
        for (int t = 0; t < `PERIPH_NUM_TGT; t++) begin
            if (en_hit[t]) begin
                rdata_o = bus_pkg::data_t'({enable_q[t], 1'b0});
            end
            if (thr_hit[t]) begin
                rdata_o = bus_pkg::data_t'(thresh_q[t]);
            end
            if (claim_hit[t]) begin
                rdata_o = bus_pkg::data_t'(max_id_q[t]);
            end
        end
    end

    // Claim on read, complete on write
    always_comb begin
        claim_valid_o    = 1'b0;
        claim_id_o       = '0;
        complete_valid_o = 1'b0;
        complete_id_o    = wdata_i[2:0];
        for (int t = 0; t < `PERIPH_NUM_TGT; t++) begin
            if (sel_i && claim_hit[t]) begin
                if (we_i) begin
                    complete_valid_o = 1'b1;
                end else if (max_id_q[t] != '0) begin
                    claim_valid_o = 1'b1;
                    claim_id_o    = max_id_q[t];
                end
            end
        end
    end

    // --------------------
    // Target selection
    // --------------------
    // Starting from the threshold gives the strict compare, ascending ids win ties
    always_comb begin
        for (int t = 0; t < `PERIPH_NUM_TGT; t++) begin
            best_id[t]   = '0;
            best_prio[t] = thresh_q[t];
            for (int s = 0; s < `PERIPH_NUM_SRC; s++) begin
                if (pending_i[s] && enable_q[t][s] && prio_q[s] > best_prio[t]) begin
                    best_id[t]   = irq_pkg::src_id_t'(s + 1);
                    best_prio[t] = prio_q[s];
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prio_q   <= '{default: '0};
            enable_q <= '{default: '0};
            thresh_q <= '{default: '0};
            max_id_q <= '{default: '0};
            irq_o    <= '0;
        end else begin
            for (int s = 0; s < `PERIPH_NUM_SRC; s++) begin
                if (sel_i && we_i && prio_hit[s]) begin
                    prio_q[s] <= wdata_i[`PERIPH_PRIO_W-1:0];
                end
            end
            for (int t = 0; t < `PERIPH_NUM_TGT; t++) begin
                if (sel_i && we_i && en_hit[t]) begin
                    enable_q[t] <= wdata_i[`PERIPH_NUM_SRC:1];
                end
                if (sel_i && we_i && thr_hit[t]) begin
                    thresh_q[t] <= wdata_i[`PERIPH_PRIO_W-1:0];
                end
                irq_o[t] <= (best_id[t] != '0);
            end
            max_id_q <= best_id;
        end
    end

    assert property (@(posedge clk_i) disable iff (!arst_n_i) claim_valid_o |-> claim_id_o != '0);

endmodule

/* rtl/periph_top.sv */
// Peripheral subsystem top, joins the register decoder, timers and interrupt pipeline
`timescale 1ns/1ps
`include "periph_config.svh"

module periph_top (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       req_i,
    input  logic                       we_i,
    input  bus_pkg::addr_t             addr_i,
    input  bus_pkg::data_t             wdata_i,
    input  logic [1:0]                 ext_irq_i,
    output logic                       rvalid_o,
    output bus_pkg::data_t             rdata_o,
    output logic                       err_o,
    output logic [`PERIPH_NUM_TGT-1:0] irq_o
);

    logic                         plic_sel;
    logic                         timer_sel;
    logic                         we;
    bus_pkg::offset_t             offset;
    bus_pkg::data_t               wdata;
    bus_pkg::data_t               plic_rdata;
    bus_pkg::data_t               timer_rdata;
    logic [`PERIPH_TIMER_CNT-1:0] timer_irq;
    irq_pkg::src_vec_t            src;
    irq_pkg::src_vec_t            pending;
    logic                         claim_valid;
    irq_pkg::src_id_t             claim_id;
    logic                         complete_valid;
    irq_pkg::src_id_t             complete_id;

    // Timers are ids 1 and 2, external lines ids 3 and 4
    assign src = {ext_irq_i, timer_irq};

    reg_decode i_reg_decode (
        .clk_i         ( clk_i       ),
        .arst_n_i      ( arst_n_i    ),
        .req_i         ( req_i       ),
        .we_i          ( we_i        ),
        .addr_i        ( addr_i      ),
        .wdata_i       ( wdata_i     ),
        .plic_rdata_i  ( plic_rdata  ),
        .timer_rdata_i ( timer_rdata ),
        .plic_sel_o    ( plic_sel    ),
        .timer_sel_o   ( timer_sel   ),
        .we_o          ( we          ),
        .offset_o      ( offset      ),
        .wdata_o       ( wdata       ),
        .rvalid_o      ( rvalid_o    ),
        .rdata_o       ( rdata_o     ),
        .err_o         ( err_o       )
    );

    timer_bank i_timer_bank (
        .clk_i    ( clk_i       ),
        .arst_n_i ( arst_n_i    ),
        .sel_i    ( timer_sel   ),
        .we_i     ( we          ),
        .offset_i ( offset      ),
        .wdata_i  ( wdata       ),
        .rdata_o  ( timer_rdata ),
        .irq_o    ( timer_irq   )
    );

    irq_gateway i_irq_gateway (
        .clk_i            ( clk_i          ),
        .arst_n_i         ( arst_n_i       ),
        .src_i            ( src            ),
        .claim_valid_i    ( claim_valid    ),
        .claim_id_i       ( claim_id       ),
        .complete_valid_i ( complete_valid ),
        .complete_id_i    ( complete_id    ),
        .pending_o        ( pending        )
    );

    irq_arbiter i_irq_arbiter (
        .clk_i            ( clk_i          ),
        .arst_n_i         ( arst_n_i       ),
        .sel_i            ( plic_sel       ),
        .we_i             ( we             ),
        .offset_i         ( offset         ),
        .wdata_i          ( wdata          ),
        .pending_i        ( pending        ),
        .rdata_o          ( plic_rdata     ),
        .claim_valid_o    ( claim_valid    ),
        .claim_id_o       ( claim_id       ),
        .complete_valid_o ( complete_valid ),
        .complete_id_o    ( complete_id    ),
        .irq_o            ( irq_o          )
    );

endmodule

/* dv/periph_tb.sv */
// Top-level testbench that drives and checks the peripheral subsystem as the simulation top
`timescale 1ns/1ps
`include "periph_config.svh"

module periph_tb;

    // Rough length of the whole stimulus in clock cycles
    localparam int STIM_CYCLES = 250;

    logic                       clk_i;
    logic                       arst_n_i;
    logic                       req_i;
    logic                       we_i;
    bus_pkg::addr_t             addr_i;
    bus_pkg::data_t             wdata_i;
    logic [1:0]                 ext_irq_i;
    logic                       rvalid_o;
    bus_pkg::data_t             rdata_o;
    logic                       err_o;
    logic [`PERIPH_NUM_TGT-1:0] irq_o;

    // Expected values set on the falling edge before the checking edge
    logic                       rsp_chk;
    logic                       data_chk;
    bus_pkg::data_t             exp_rdata;
    logic                       exp_err;
    logic [`PERIPH_NUM_TGT-1:0] irq_chk;
    logic [`PERIPH_NUM_TGT-1:0] exp_irq;
    logic                       tmr_armed;
    int                         wait_cnt;
    int                         tmr_limit;

    periph_top DUT (
        .clk_i     ( clk_i     ),
        .arst_n_i  ( arst_n_i  ),
        .req_i     ( req_i     ),
        .we_i      ( we_i      ),
        .addr_i    ( addr_i    ),
        .wdata_i   ( wdata_i   ),
        .ext_irq_i ( ext_irq_i ),
        .rvalid_o  ( rvalid_o  ),
        .rdata_o   ( rdata_o   ),
        .err_o     ( err_o     ),
        .irq_o     ( irq_o     )
    );

    always #50 clk_i = ~clk_i;

    task automatic stop_on_failure();
        $display("Test failures found");
        $fatal(1, "Stopped at the first failing check");
    endtask

    // --------------------
    // Checks
    // --------------------
    assert property (@(posedge clk_i) disable iff (!arst_n_i) rsp_chk |-> rvalid_o)
        else begin
            $display("CHECK FAILED: rvalid_o expected %h got %h", 1'b1, $sampled(rvalid_o));
            stop_on_failure();
        end

    assert property (@(posedge clk_i) disable iff (!arst_n_i) rsp_chk |-> err_o == exp_err)
        else begin
            $display("CHECK FAILED: err_o expected %h got %h", exp_err, $sampled(err_o));
            stop_on_failure();
        end

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rsp_chk && data_chk |-> rdata_o == exp_rdata)
        else begin
            $display("CHECK FAILED: rdata_o expected %h got %h", exp_rdata, $sampled(rdata_o));
            stop_on_failure();
        end

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        irq_chk != '0 |-> ((irq_o ^ exp_irq) & irq_chk) == '0)
        else begin
            $display("CHECK FAILED: irq_o expected %h got %h (mask %h)",
                     exp_irq, $sampled(irq_o), irq_chk);
            stop_on_failure();
        end

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        tmr_armed && wait_cnt == tmr_limit |-> irq_o[1])
        else begin
            $display("Timer interrupt on target 1 did not rise within %0d cycles of enable",
                     tmr_limit);
            stop_on_failure();
        end

    // --------------------
    // Address map helpers
    // --------------------
    function automatic bus_pkg::addr_t prio_addr(int id);
        return {bus_pkg::REGION_PLIC, bus_pkg::PRIO_BASE + bus_pkg::offset_t'(4 * id)};
    endfunction

    function automatic bus_pkg::addr_t enable_addr(int t);
        return {bus_pkg::REGION_PLIC, bus_pkg::ENABLE_BASE + bus_pkg::offset_t'(4 * t)};
    endfunction

    function automatic bus_pkg::addr_t thresh_addr(int t);
        return {bus_pkg::REGION_PLIC, bus_pkg::THRESH_BASE + bus_pkg::offset_t'(8 * t)};
    endfunction

    function automatic bus_pkg::addr_t claim_addr(int t);
        return {bus_pkg::REGION_PLIC, bus_pkg::THRESH_BASE + bus_pkg::offset_t'(8 * t + 4)};
    endfunction

    // Register offset 0 is control, 4 count and 8 compare
    function automatic bus_pkg::addr_t timer_addr(int n, int reg_off);
        return {bus_pkg::REGION_TIMER,
                bus_pkg::offset_t'(n) * bus_pkg::TIMER_STRIDE + bus_pkg::offset_t'(reg_off)};
    endfunction

    // One request with its response checked on the edge after it
    task automatic bus_access(input logic we, input bus_pkg::addr_t addr,
                              input bus_pkg::data_t wdata, input logic chk,
                              input bus_pkg::data_t exp_data, input logic err);
        @(negedge clk_i);
        req_i     = 1'b1;
        we_i      = we;
        addr_i    = addr;
        wdata_i   = wdata;
        data_chk  = chk;
        exp_rdata = exp_data;
        exp_err   = err;
        @(negedge clk_i);
        req_i   = 1'b0;
        rsp_chk = 1'b1;
        @(negedge clk_i);
        rsp_chk = 1'b0;
    endtask

    task automatic write_reg(input bus_pkg::addr_t addr, input bus_pkg::data_t data);
        bus_access(1'b1, addr, data, 1'b0, '0, 1'b0);
    endtask

    task automatic read_check(input bus_pkg::addr_t addr, input bus_pkg::data_t exp_data);
        bus_access(1'b0, addr, '0, 1'b1, exp_data, 1'b0);
    endtask

    // Starts on a falling edge and checks the masked irq_o bits on the next n rising edges
    task automatic hold_irq_check(input logic [1:0] mask, input logic [1:0] value, input int n);
        irq_chk = mask;
        exp_irq = value;
        repeat (n) @(negedge clk_i);
        irq_chk = '0;
    endtask

    initial begin
        bus_pkg::data_t wval;
        bus_pkg::addr_t uaddr;
        int             cmp;
        void'($urandom(32'h522f_9a7d));
        clk_i     = 1'b0;
        arst_n_i  = 1'b0;
        req_i     = 1'b0;
        we_i      = 1'b0;
        addr_i    = '0;
        wdata_i   = '0;
        ext_irq_i = '0;
        rsp_chk   = 1'b0;
        data_chk  = 1'b0;
        exp_rdata = '0;
        exp_err   = 1'b0;
        irq_chk   = '0;
        exp_irq   = '0;
        tmr_armed = 1'b0;
        wait_cnt  = 0;
        tmr_limit = 0;
        repeat (5) @(negedge clk_i);
        arst_n_i = 1'b1;
        @(negedge clk_i);

        // Regions 2 to 15 are unmapped
        for (int i = 0; i < 8; i++) begin
            uaddr = {bus_pkg::region_t'(2 + $urandom_range(13)), 12'($urandom)};
            bus_access(i[0], uaddr, $urandom, 1'b1, `PERIPH_UNMAPPED_DATA, 1'b1);
        end

        // Register readback
        for (int id = 1; id <= `PERIPH_NUM_SRC; id++) begin
            wval = $urandom;
            write_reg(prio_addr(id), wval);
            read_check(prio_addr(id), wval & ((32'd1 << `PERIPH_PRIO_W) - 1));
        end
        for (int t = 0; t < `PERIPH_NUM_TGT; t++) begin
            wval = $urandom;
            write_reg(enable_addr(t), wval);
            read_check(enable_addr(t), wval & (((32'd1 << `PERIPH_NUM_SRC) - 1) << 1));
            wval = $urandom;
            write_reg(thresh_addr(t), wval);
            read_check(thresh_addr(t), wval & ((32'd1 << `PERIPH_PRIO_W) - 1));
        end
        for (int n = 0; n < `PERIPH_TIMER_CNT; n++) begin
            wval = $urandom;
            write_reg(timer_addr(n, 8), wval);
            read_check(timer_addr(n, 8), wval);
        end
        for (int t = 0; t < `PERIPH_NUM_TGT; t++) begin
            write_reg(enable_addr(t), '0);
            write_reg(thresh_addr(t), '0);
        end

        // External line 0 is id 3 on target 0 with threshold 2
        write_reg(prio_addr(3), 32'd5);
        write_reg(enable_addr(0), 32'h8);
        write_reg(thresh_addr(0), 32'd2);
        ext_irq_i[0] = 1'b1;
        hold_irq_check(2'b01, 2'b00, 2);
        hold_irq_check(2'b01, 2'b01, 2);
        write_reg(prio_addr(3), 32'd2);
        hold_irq_check(2'b01, 2'b00, 4);
        write_reg(prio_addr(3), 32'd1);
        hold_irq_check(2'b01, 2'b00, 4);
        write_reg(prio_addr(3), 32'd5);

        // Claim returns the higher priority first and the lowest id on a tie
        write_reg(prio_addr(4), 32'd6);
        write_reg(enable_addr(0), 32'h18);
        ext_irq_i[1] = 1'b1;
        repeat (3) @(negedge clk_i);
        read_check(claim_addr(0), 32'd4);
        write_reg(claim_addr(0), 32'd4);
        write_reg(prio_addr(4), 32'd5);
        repeat (2) @(negedge clk_i);
        read_check(claim_addr(0), 32'd3);
        read_check(claim_addr(0), 32'd4);
        hold_irq_check(2'b01, 2'b00, 4);

        // Complete of id 3 re-arms it while its line is still high
        write_reg(claim_addr(0), 32'd3);
        hold_irq_check(2'b01, 2'b00, 1);
        hold_irq_check(2'b01, 2'b01, 2);

        // Timer 0 is id 1 and routes to target 1
        cmp = 4 + $urandom_range(12);
        write_reg(prio_addr(1), 32'd3);
        write_reg(enable_addr(1), 32'h2);
        write_reg(thresh_addr(1), 32'd0);
        write_reg(timer_addr(0, 8), cmp);
        write_reg(timer_addr(0, 4), '0);
        write_reg(timer_addr(0, 0), 32'd1);
        tmr_limit = cmp + 4;
        wait_cnt  = 2;
        tmr_armed = 1'b1;
        while (!irq_o[1] && wait_cnt <= tmr_limit) begin
            @(negedge clk_i);
            wait_cnt++;
        end
        tmr_armed = 1'b0;
        read_check(claim_addr(1), 32'd1);
        write_reg(timer_addr(0, 0), '0);

        repeat (2) @(negedge clk_i);
        $display("All tests passed!");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (4 * STIM_CYCLES + 200) @(posedge clk_i);
        $display("Run timed out before the test sequence finished");
        $display("Test failures found");
        $fatal(1, "Watchdog expired");
    end

endmodule

/* compile.f */
+incdir+rtl
rtl/bus_pkg.sv
rtl/irq_pkg.sv
rtl/reg_decode.sv
rtl/timer_bank.sv
rtl/irq_gateway.sv
rtl/irq_arbiter.sv
rtl/periph_top.sv
dv/periph_tb.sv
